/* bench/saturn_bus_tb.sv */
module saturn_bus_tb
    import saturn_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF   = 20;
    localparam int RESET_CLKS = 5;
    localparam int NUM_XFERS  = 20;
    localparam int MAX_BYTES  = 12;
    // a transfer is seven setup cycles plus two read cycles per byte, four clocks each
    localparam int XFER_CLKS  = (7 + 2 * MAX_BYTES) * 4;
    // clock enable gaps and a slow reader may stretch every clock by up to this factor
    localparam int MARGIN     = 8;
    localparam int LIMIT_CLKS = NUM_XFERS * XFER_CLKS * MARGIN + RESET_CLKS;
    localparam int SEED       = 75929;

    logic                 i_clk = 1'b0;
    logic                 i_reset;
    logic                 i_clk_en;
    logic                 i_start;
    logic [ADDR_BITS-1:0] i_start_addr;
    logic [7:0]           i_byte_count;
    bus_phase_t           o_phase;
    logic [31:0]          o_cycle_ctr;
    logic [7:0]           o_char;
    logic                 o_char_valid;
    logic                 i_char_ready;
    logic                 o_halt;

    // reference copy of the firmware image
    logic [3:0]  rom_model [ROM_NIBBLES];
    // bytes the reader still has to see, oldest first
    logic [7:0]  expected [$];
    int          cur_count = 0;
    int          rx_count = 0;
    int          error_count = 0;
    // the bus noise and the transfer parameters each draw from their own stream
    logic [31:0] noise_state = SEED;
    logic [31:0] param_state = ~SEED;

    // values seen on the previous clock edge
    bus_phase_t  prev_phase;
    logic [31:0] prev_ctr;
    logic        prev_clk_en;
    logic        prev_valid;
    logic        prev_ready;
    logic [7:0]  prev_char;
    logic        prev_halt;
    logic        prev_start;
    logic [7:0]  want_char;

    saturn_bus dut0 (.*);

    always #CLK_HALF i_clk = ~i_clk;

    function automatic logic [31:0] xorshift_next(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            error_count++;
            $display("FAILED at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, want);
            $display("*** FAILED ***");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        error_count++;
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run aborted");
    endtask

    // expected byte k pairs the nibble after the start with the one at the start
    task automatic load_expected(input logic [ADDR_BITS-1:0] addr, input int count);
        int lo_idx;
        int hi_idx;
        for (int k = 0; k < count; k++) begin
            lo_idx = (int'(addr % ADDR_BITS'(ROM_NIBBLES)) + 2 * k) % ROM_NIBBLES;
            hi_idx = (lo_idx + 1) % ROM_NIBBLES;
            expected.push_back({rom_model[hi_idx], rom_model[lo_idx]});
        end
    endtask

    task automatic start_transfer(input logic [ADDR_BITS-1:0] addr, input logic [7:0] count);
        i_start_addr <= addr;
        i_byte_count <= count;
        i_start      <= 1'b1;
        @(posedge i_clk);
        i_start      <= 1'b0;
    endtask

    task automatic wait_for_halt();
        do begin
            @(posedge i_clk);
        end while (!o_halt);
    endtask

    // clock enable is up about three clocks in four, the reader is ready about half the time
    always @(posedge i_clk) begin
        noise_state = xorshift_next(noise_state);
        i_clk_en     <= (noise_state[1:0] != 2'b00);
        i_char_ready <= noise_state[8];
    end

    // everything here reads the values from before the edge, so it sees a settled bus
    always @(posedge i_clk) begin
        if (!i_reset) begin
            if (!prev_clk_en) begin
                check_equal(32'(o_phase), 32'(prev_phase), "phase moved with clock enable low");
            end else if (o_phase != prev_phase) begin
                check_equal(32'(o_phase), 32'(bus_phase_t'(prev_phase + 2'd1)),
                            "phase did not step by one");
            end
            if (prev_phase == 2'd3 && o_phase == 2'd0) begin
                check_equal(o_cycle_ctr, prev_ctr + 32'd1, "cycle counter missed a bus cycle");
            end else begin
                check_equal(o_cycle_ctr, prev_ctr, "cycle counter moved inside a bus cycle");
            end
            // a byte the reader refused must wait unchanged
            if (prev_valid && !prev_ready) begin
                check_equal(32'(o_char_valid), 32'd1, "valid dropped before the byte was taken");
                check_equal(32'(o_char), 32'(prev_char), "byte changed while held");
            end
            if (o_char_valid && i_char_ready) begin
                if (expected.size() == 0) begin
                    abort_run($sformatf("a byte 0x%02h arrived that no transfer asked for at %0t",
                                        o_char, $time));
                end
                want_char = expected.pop_front();
                check_equal(32'(o_char), 32'(want_char), "wrong byte accepted");
                rx_count++;
            end
            if (o_halt) begin
                check_equal(32'(o_char_valid), 32'd0, "byte offered after halt");
            end
            if (o_halt && !prev_halt) begin
                check_equal(32'(rx_count), 32'(cur_count), "halt rose before the last byte");
            end
            if (prev_halt && !o_halt) begin
                check_equal(32'(prev_start), 32'd1, "halt fell without a new start");
            end
        end
        prev_phase  = o_phase;
        prev_ctr    = o_cycle_ctr;
        prev_clk_en = i_clk_en;
        prev_valid  = o_char_valid;
        prev_ready  = i_char_ready;
        prev_char   = o_char;
        prev_halt   = o_halt;
        prev_start  = i_start;
    end

    initial begin
        #(LIMIT_CLKS * 2 * CLK_HALF);
        abort_run($sformatf("timeout, the transfers did not finish within %0d clocks",
                            LIMIT_CLKS));
    end

    initial begin
        logic [ADDR_BITS-1:0] addr;
        int                   count;
        $readmemh("hw/saturn_rom.hex", rom_model);
        i_reset      = 1'b1;
        i_clk_en     = 1'b0;
        i_start      = 1'b0;
        i_start_addr = '0;
        i_byte_count = '0;
        i_char_ready = 1'b0;
        repeat (RESET_CLKS) @(posedge i_clk);
        check_equal(32'(o_char_valid), 32'd0, "valid high after reset");
        check_equal(32'(o_halt), 32'd0, "halt high after reset");
        check_equal(32'(o_phase), 32'd0, "phase not zero after reset");
        check_equal(o_cycle_ctr, 32'd0, "cycle counter not zero after reset");
        i_reset <= 1'b0;
        for (int xfer = 0; xfer < NUM_XFERS; xfer++) begin
            param_state = xorshift_next(param_state);
            repeat (1 + int'(param_state[1:0])) @(posedge i_clk);
            param_state = xorshift_next(param_state);
            addr = param_state[ADDR_BITS-1:0];
            param_state = xorshift_next(param_state);
            count = 1 + int'(param_state % 32'(MAX_BYTES));
            // the first transfer starts near the top of the image so the pointer wraps
            if (xfer == 0) begin
                addr[4:0] = 5'd27;
                count     = MAX_BYTES;
            end
            load_expected(addr, count);
            cur_count = count;
            rx_count  = 0;
            start_transfer(addr, 8'(count));
            wait_for_halt();
            check_equal(32'(rx_count), 32'(count), "byte count of transfer");
            check_equal(32'(expected.size()), 32'd0, "bytes left over after halt");
        end
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* hw/saturn_bus.sv */
module saturn_bus
    import saturn_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_clk_en,
    input  logic                 i_start,
    input  logic [ADDR_BITS-1:0] i_start_addr,
    input  logic [7:0]           i_byte_count,
    output bus_phase_t           o_phase,
    output logic [31:0]          o_cycle_ctr,
    output logic [7:0]           o_char,
    output logic                 o_char_valid,
    input  logic                 i_char_ready,
    output logic                 o_halt
);

    // one-hot phase register, bit n set means the bus is in phase n
    logic [3:0] phases;
    logic       bus_clk_en;
    logic       stall;
    bus_word_t  ctrl_word;
    logic [3:0] rom_nibble;
    logic [3:0] rd_nibble;
    logic       push;
    logic [7:0] push_byte;
    logic       fifo_full;
    logic       fifo_empty;

    // the bus only moves when the clock enable is up and the controller is not stalled
    assign bus_clk_en = i_clk_en && !stall;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phases      <= 4'b0001;
            o_cycle_ctr <= '0;
        end else if (bus_clk_en) begin
            phases <= {phases[2:0], phases[3]};
            // leaving phase 3 opens a new bus cycle
            if (phases[3]) begin
                o_cycle_ctr <= o_cycle_ctr + 32'd1;
            end
        end
    end

    always_comb begin
        o_phase = 2'd0;
        case (1'b1)
            phases[1]: o_phase = 2'd1;
            phases[2]: o_phase = 2'd2;
            phases[3]: o_phase = 2'd3;
            default:   o_phase = 2'd0;
        endcase
    end

    // read-data selection, later sources win over earlier ones
    // the firmware ROM is the only bus target for now
    always_comb begin
        rd_nibble = 4'h0;
        rd_nibble = rom_nibble;
    end

    saturn_bus_controller bus_controller (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_bus_clk_en (bus_clk_en),
        .i_phase      (o_phase),
        .i_start      (i_start),
        .i_start_addr (i_start_addr),
        .i_byte_count (i_byte_count),
        .o_bus_word   (ctrl_word),
        .i_bus_nibble (rd_nibble),
        .o_stall      (stall),
        .o_push       (push),
        .o_push_byte  (push_byte),
        .i_fifo_full  (fifo_full),
        .i_fifo_empty (fifo_empty),
        .o_halt       (o_halt)
    );

    saturn_rom firmware_rom (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_bus_clk_en (bus_clk_en),
        .i_phase      (o_phase),
        .i_bus_word   (ctrl_word),
        .o_bus_nibble (rom_nibble)
    );

    saturn_char_fifo char_fifo (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_push       (push),
        .i_push_byte  (push_byte),
        .o_full       (fifo_full),
        .o_empty      (fifo_empty),
        .o_char       (o_char),
        .o_char_valid (o_char_valid),
        .i_char_ready (i_char_ready)
    );

    // a lost or doubled phase bit would desynchronize every device on the bus
    assert property (@(posedge i_clk) disable iff (i_reset) $onehot(phases));

endmodule

/* hw/saturn_bus_controller.sv */
module saturn_bus_controller
    import saturn_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_bus_clk_en,
    input  bus_phase_t           i_phase,
    input  logic                 i_start,
    input  logic [ADDR_BITS-1:0] i_start_addr,
    input  logic [7:0]           i_byte_count,
    output bus_word_t            o_bus_word,
    input  logic [3:0]           i_bus_nibble,
    output logic                 o_stall,
    output logic                 o_push,
    output logic [7:0]           o_push_byte,
    input  logic                 i_fifo_full,
    input  logic                 i_fifo_empty,
    output logic                 o_halt
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_CMD,
        S_ADDR,
        S_READ_CMD,
        S_READ,
        S_DONE
    } state_t;

    state_t                   state;
    // a start waits here until the next bus cycle boundary
    logic                     start_pend;
    logic                     start_ok;
    logic [ADDR_BITS-1:0]     addr_q;
    logic [ADDR_IDX_BITS-1:0] nib_idx;
    logic [7:0]               bytes_left;
    // set while the next returned nibble is the high half of a byte
    logic                     hi_nibble;
    logic [3:0]               low_nib;
    logic                     cycle_end;
    logic                     byte_due;

    // a new transfer is only taken between transfers
    assign start_ok  = i_start && (state == S_IDLE || state == S_DONE);
    // the state steps on the enabled clock that closes phase 3
    assign cycle_end = i_bus_clk_en && (i_phase == PH_CAPTURE);

    // the high nibble is on the read path in phase 3, so the byte is complete
    assign byte_due    = (state == S_READ) && hi_nibble && (i_phase == PH_CAPTURE);
    assign o_stall     = byte_due && i_fifo_full;
    assign o_push      = byte_due && i_bus_clk_en;
    assign o_push_byte = {i_bus_nibble, low_nib};

    // done only counts once the reader has drained every byte
    assign o_halt = (state == S_DONE) && i_fifo_empty;

    // bus word for the current cycle, held from phase 0 until the state steps
    always_comb begin
        o_bus_word.is_data     = 1'b0;
        o_bus_word.nibble.data = BUS_PARK_NIBBLE;
        case (state)
            S_LOAD_CMD: o_bus_word.nibble.cmd = CMD_LOAD_PC;
            S_ADDR: begin
                o_bus_word.is_data     = 1'b1;
                o_bus_word.nibble.data = addr_q[3:0];
            end
            S_READ_CMD: o_bus_word.nibble.cmd = CMD_PC_READ;
            S_READ: begin
                // a data cycle in read mode, the ROM drives the nibble back
                o_bus_word.is_data     = 1'b1;
                o_bus_word.nibble.data = 4'h0;
            end
            default: o_bus_word.nibble.data = BUS_PARK_NIBBLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state      <= S_IDLE;
            start_pend <= 1'b0;
            nib_idx    <= '0;
            bytes_left <= '0;
            hi_nibble  <= 1'b0;
        end else if (start_ok) begin
            state      <= S_IDLE;
            start_pend <= 1'b1;
            bytes_left <= i_byte_count;
        end else if (cycle_end) begin
            case (state)
                S_IDLE: begin
                    if (start_pend) begin
                        state      <= S_LOAD_CMD;
                        start_pend <= 1'b0;
                    end
                end
                S_LOAD_CMD: begin
                    state   <= S_ADDR;
                    nib_idx <= '0;
                end
                S_ADDR: begin
                    if (nib_idx == ADDR_IDX_BITS'(ADDR_NIBBLES - 1)) begin
                        state <= S_READ_CMD;
                    end else begin
                        nib_idx <= nib_idx + 1'b1;
                    end
                end
                S_READ_CMD: begin
                    hi_nibble <= 1'b0;
                    state     <= (bytes_left == 8'd0) ? S_DONE : S_READ;
                end
                S_READ: begin
                    hi_nibble <= !hi_nibble;
                    if (hi_nibble) begin
                        bytes_left <= bytes_left - 8'd1;
                        if (bytes_left == 8'd1) begin
                            state <= S_DONE;
                        end
                    end
                end
                default: state <= state;
            endcase
        end
    end

    // address shifts out low nibble first, the low nibble of each byte is parked here
    always_ff @(posedge i_clk) begin
        if (start_ok) begin
            addr_q <= i_start_addr;
        end else if (cycle_end && state == S_ADDR) begin
            addr_q <= addr_q >> 4;
        end
        if (cycle_end && state == S_READ && !hi_nibble) begin
            low_nib <= i_bus_nibble;
        end
    end

    // the FIFO must never see a push it cannot store
    assert property (@(posedge i_clk) disable iff (i_reset) o_push |-> !i_fifo_full);

    // a stalled byte must survive the stall, so the frozen bus keeps its nibble
    assert property (@(posedge i_clk) disable iff (i_reset) o_stall |=> $stable(o_push_byte));

endmodule

/* hw/saturn_char_fifo.sv */
module saturn_char_fifo
    import saturn_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_push,
    input  logic [7:0] i_push_byte,
    output logic       o_full,
    output logic       o_empty,
    output logic [7:0] o_char,
    output logic       o_char_valid,
    input  logic       i_char_ready
);

    logic [7:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wptr;
    logic [FIFO_AW-1:0] rptr;
    logic [FIFO_CW-1:0] count;
    logic               pop;

    assign o_empty      = (count == '0);
    assign o_full       = (count == FIFO_CW'(FIFO_DEPTH));
    assign o_char_valid = !o_empty;
    // the head entry is shown directly, it only moves on a pop
    assign o_char       = mem[rptr];
    assign pop          = o_char_valid && i_char_ready;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (i_push) begin
                wptr <= wptr + 1'b1;
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
            // a push and a pop in the same clock leave the count alone
            case ({i_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wptr] <= i_push_byte;
        end
    end

    // a push into a full ring is only allowed if the head leaves in the same clock
    assert property (@(posedge i_clk) disable iff (i_reset) i_push |-> (!o_full || pop));

    // the occupancy never wraps below zero or past the depth
    // and it always matches the distance between the two pointers
    assert property (@(posedge i_clk) disable iff (i_reset)
        (count <= FIFO_CW'(FIFO_DEPTH)) && (FIFO_AW'(wptr - rptr) == count[FIFO_AW-1:0]));

endmodule

/* hw/saturn_pkg.sv */
package saturn_pkg;

    // a bus address is five nibbles wide and travels low nibble first
    localparam int ADDR_NIBBLES  = 5;
    localparam int ADDR_BITS     = 4 * ADDR_NIBBLES;
    localparam int ADDR_IDX_BITS = $clog2(ADDR_NIBBLES);

    // firmware image size in nibbles, the read pointer wraps inside this window
    localparam int    ROM_NIBBLES = 32;
    localparam int    ROM_AW      = $clog2(ROM_NIBBLES);
    localparam string ROM_FILE    = "hw/saturn_rom.hex";

    // character FIFO sizing, the count needs one more bit than the pointers
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int FIFO_CW    = $clog2(FIFO_DEPTH + 1);

    // the phases in which a device acts inside a bus cycle
    // phase 0 is left to the controller to present its word
    localparam logic [1:0] PH_SAMPLE  = 2'd1;
    localparam logic [1:0] PH_RETURN  = 2'd2;
    localparam logic [1:0] PH_CAPTURE = 2'd3;

    // saturn bus command codes used by this core
    typedef enum logic [3:0] {
        CMD_PC_READ = 4'h0,
        CMD_LOAD_PC = 4'h4
    } bus_cmd_t;

    // unassigned command code that parks the bus between transfers
    // any device that decodes it drops out of its current mode
    localparam logic [3:0] BUS_PARK_NIBBLE = 4'hf;

    // one bus nibble, read as a command or as raw data depending on is_data
    typedef union packed {
        bus_cmd_t   cmd;
        logic [3:0] data;
    } bus_nibble_u;

    // what the controller drives onto the bus for one bus cycle
    typedef struct packed {
        logic        is_data;
        bus_nibble_u nibble;
    } bus_word_t;

    // phase number inside a bus cycle, 0 to 3
    typedef logic [1:0] bus_phase_t;

endpackage

/* hw/saturn_rom.hex */
// firmware image, one hex nibble per line
// line n below holds the nibble at ROM address n, 0 to 31
3
a
7
1
e
5
c
0
9
4
f
2
b
6
d
8
1
c
4
9
0
e
7
b
2
f
5
a
8
3
6
d

/* hw/saturn_rom.sv */
module saturn_rom
    import saturn_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_bus_clk_en,
    input  bus_phase_t i_phase,
    input  bus_word_t  i_bus_word,
    output logic [3:0] o_bus_nibble
);

    // idle ignores data, addr gathers the pointer, read streams nibbles out
    typedef enum logic [1:0] {
        M_IDLE,
        M_ADDR,
        M_READ
    } mode_t;

    mode_t                    mode;
    logic [ADDR_IDX_BITS-1:0] addr_cnt;
    // a data word was taken in read mode and its nibble is owed in phase 2
    logic                     rd_pending;
    logic [ADDR_BITS-1:0]     pointer;
    logic [3:0]               rom_mem [ROM_NIBBLES];
    logic                     sample;
    logic                     ret;

    initial begin
        $readmemh(ROM_FILE, rom_mem);
    end

    assign sample = i_bus_clk_en && (i_phase == PH_SAMPLE);
    assign ret    = i_bus_clk_en && (i_phase == PH_RETURN);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            mode       <= M_IDLE;
            addr_cnt   <= '0;
            rd_pending <= 1'b0;
        end else begin
            if (ret) begin
                rd_pending <= 1'b0;
            end
            if (sample) begin
                if (!i_bus_word.is_data) begin
                    case (i_bus_word.nibble.cmd)
                        CMD_LOAD_PC: begin
                            mode     <= M_ADDR;
                            addr_cnt <= '0;
                        end
                        CMD_PC_READ: mode <= M_READ;
                        default:     mode <= M_IDLE;
                    endcase
                end else if (mode == M_ADDR) begin
                    // the fifth address nibble closes the load
                    if (addr_cnt == ADDR_IDX_BITS'(ADDR_NIBBLES - 1)) begin
                        mode <= M_IDLE;
                    end
                    addr_cnt <= addr_cnt + 1'b1;
                end else if (mode == M_READ) begin
                    rd_pending <= 1'b1;
                end
            end
        end
    end

    // address nibbles enter at the top so the first one ends up lowest
    always_ff @(posedge i_clk) begin
        if (sample && i_bus_word.is_data && mode == M_ADDR) begin
            pointer <= {i_bus_word.nibble.data, pointer[ADDR_BITS-1:4]};
        end
        if (ret && rd_pending) begin
            o_bus_nibble         <= rom_mem[pointer[ROM_AW-1:0]];
            // only the image window advances, so the pointer wraps inside it
            pointer[ROM_AW-1:0] <= pointer[ROM_AW-1:0] + 1'b1;
        end
    end

    // the controller may only send data once a command has set up a mode
    assert property (@(posedge i_clk) disable iff (i_reset)
        (sample && i_bus_word.is_data) |-> (mode != M_IDLE));

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module saturn_bus_tb -f src.f -o saturn_bus_sim \
    && ./obj_dir/saturn_bus_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

/* src.f */
hw/saturn_pkg.sv
hw/saturn_bus_controller.sv
hw/saturn_rom.sv
hw/saturn_char_fifo.sv
hw/saturn_bus.sv
bench/saturn_bus_tb.sv
